// ==== i3c_dxt_settings.svh ====
// ********************
// Device table sizes
// ********************

`ifndef I3C_DXT_SETTINGS_SVH
`define I3C_DXT_SETTINGS_SVH

// Number of entries per table
`define DAT_DEPTH 128
`define DCT_DEPTH 128

// Entry widths in bits
`define DAT_WIDTH 64
`define DCT_WIDTH 128

// Software byte address width
`define CSR_AW 12

`endif

// ==== i3c_dxt_pkg.sv ====
// ********************
// Device table types
// ********************

`include "i3c_dxt_settings.svh"

package i3c_dxt_pkg;

  typedef enum logic {
    CSR_READ,
    CSR_WRITE
  } csr_op_e;

  typedef enum logic {
    TBL_DAT,
    TBL_DCT
  } table_sel_e;

  typedef enum logic [1:0] {
    AG_IDLE,
    AG_ISSUE,
    AG_WAIT,
    AG_RESP
  } agent_state_e;

  // Byte address, bits 1:0 unused, then word select, then entry index
  typedef logic [`CSR_AW-1:0] csr_addr_t;
  typedef logic [31:0] csr_word_t;

  typedef logic [$clog2(`DAT_DEPTH)-1:0] dat_index_t;
  typedef logic [$clog2(`DCT_DEPTH)-1:0] dct_index_t;
  typedef logic [`DAT_WIDTH-1:0] dat_entry_t;
  typedef logic [`DCT_WIDTH-1:0] dct_entry_t;

endpackage

// ==== dxt_if.sv ====
// ********************
// Table access interfaces
// ********************

// Software word access towards one table
interface csr_hwif_if;
  import i3c_dxt_pkg::*;

  logic      req;
  logic      req_is_wr;
  csr_addr_t addr;
  csr_word_t wr_data;
  csr_word_t rd_data;
  logic      rd_ack;
  logic      wr_ack;

  modport host (
    output req, req_is_wr, addr, wr_data,
    input  rd_data, rd_ack, wr_ack
  );

  modport target (
    input  req, req_is_wr, addr, wr_data,
    output rd_data, rd_ack, wr_ack
  );

endinterface

// Single-port RAM access
interface table_mem_if #(
  parameter int unsigned WIDTH = 64,
  parameter int unsigned DEPTH = 128
);

  logic                     req;
  logic                     write;
  logic [$clog2(DEPTH)-1:0] addr;
  logic [WIDTH-1:0]         wdata;
  logic [WIDTH-1:0]         wmask;
  logic [WIDTH-1:0]         rdata;

  modport ctrl (output req, write, addr, wdata, wmask, input rdata);
  modport ram (input req, write, addr, wdata, wmask, output rdata);

endinterface

// ==== table_ram.sv ====
// ********************
// Table RAM
// ********************

module table_ram #(
  parameter int unsigned WIDTH = 64,
  parameter int unsigned DEPTH = 128
) (
  input logic      clk_i,
  table_mem_if.ram mem
);

  logic [WIDTH-1:0] entries_q [DEPTH];
  logic [WIDTH-1:0] merged;

  // Only bits set in the mask take the new data
  assign merged = (entries_q[mem.addr] & ~mem.wmask) | (mem.wdata & mem.wmask);

  always_ff @(posedge clk_i) begin
    if (mem.req) begin
      if (mem.write) begin
        entries_q[mem.addr] <= merged;
      end
      // Read returns the entry as it was before this edge
      mem.rdata <= entries_q[mem.addr];
    end
  end

endmodule

// ==== dxt.sv ====
// ********************
// DAT and DCT access
// ********************

module dxt (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Controller DAT read port
  input  logic                    dat_rd_valid_i,
  input  i3c_dxt_pkg::dat_index_t dat_rd_index_i,
  output i3c_dxt_pkg::dat_entry_t dat_rd_data_o,

  // Controller DCT port
  input  logic                    dct_rd_valid_i,
  input  logic                    dct_wr_valid_i,
  input  i3c_dxt_pkg::dct_index_t dct_index_i,
  input  i3c_dxt_pkg::dct_entry_t dct_wdata_i,
  output i3c_dxt_pkg::dct_entry_t dct_rd_data_o,

  // Software side
  csr_hwif_if.target              dat_csr,
  csr_hwif_if.target              dct_csr,

  // Table memories
  table_mem_if.ctrl               dat_mem,
  table_mem_if.ctrl               dct_mem
);
  import i3c_dxt_pkg::*;

  logic       dat_ctrl_busy;
  logic       dat_word_sel;
  dat_index_t dat_index_sw;
  dat_entry_t dat_wdata;
  dat_entry_t dat_wmask;
  logic       dat_rd_ack_q;
  logic       dat_wr_ack_q;

  logic       dct_ctrl_busy;
  logic [1:0] dct_word_sel;
  dct_index_t dct_index_sw;
  logic       dct_rd_ack_q;
  logic       dct_wr_ack_q;

  // DAT, two words per entry
  assign dat_ctrl_busy = dat_rd_valid_i;
  assign dat_word_sel  = dat_csr.addr[2];
  assign dat_index_sw  = dat_csr.addr[3 +: $bits(dat_index_t)];

  // Controller wins the port whenever it is active
  assign dat_mem.req   = dat_ctrl_busy | dat_csr.req;
  assign dat_mem.write = dat_csr.req & dat_csr.req_is_wr & ~dat_ctrl_busy;
  assign dat_mem.addr  = dat_ctrl_busy ? dat_rd_index_i : dat_index_sw;
  assign dat_mem.wdata = dat_wdata;
  assign dat_mem.wmask = dat_wmask;
  assign dat_rd_data_o = dat_mem.rdata;

  always_comb begin
    dat_wdata = '0;
    dat_wmask = '0;
    // Place the word in the selected half
    dat_wdata[{dat_word_sel, 5'd0} +: 32] = dat_csr.wr_data;
    dat_wmask[{dat_word_sel, 5'd0} +: 32] = '1;
  end

  // DCT, four words per entry
  assign dct_ctrl_busy = dct_rd_valid_i | dct_wr_valid_i;
  assign dct_word_sel  = dct_csr.addr[3:2];
  assign dct_index_sw  = dct_csr.addr[4 +: $bits(dct_index_t)];

  // Software never writes the DCT
  assign dct_mem.req   = dct_ctrl_busy | dct_csr.req;
  assign dct_mem.write = dct_wr_valid_i;
  assign dct_mem.addr  = dct_ctrl_busy ? dct_index_i : dct_index_sw;
  assign dct_mem.wdata = dct_wdata_i;
  assign dct_mem.wmask = {$bits(dct_entry_t){dct_wr_valid_i}};
  assign dct_rd_data_o = dct_mem.rdata;

  // Word select is still held by the agent one cycle after req
  always_ff @(posedge clk_i) begin
    dat_csr.rd_data <= dat_mem.rdata[{dat_word_sel, 5'd0} +: 32];
    dct_csr.rd_data <= dct_mem.rdata[{dct_word_sel, 5'd0} +: 32];
  end

  // Two-stage acknowledge, dropped when the controller took the table
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dat_rd_ack_q   <= 1'b0;
      dat_wr_ack_q   <= 1'b0;
      dat_csr.rd_ack <= 1'b0;
      dat_csr.wr_ack <= 1'b0;
    end else begin
      dat_rd_ack_q   <= dat_csr.req & ~dat_csr.req_is_wr & ~dat_ctrl_busy;
      dat_wr_ack_q   <= dat_csr.req & dat_csr.req_is_wr & ~dat_ctrl_busy;
      dat_csr.rd_ack <= dat_rd_ack_q;
      dat_csr.wr_ack <= dat_wr_ack_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dct_rd_ack_q   <= 1'b0;
      dct_wr_ack_q   <= 1'b0;
      dct_csr.rd_ack <= 1'b0;
      dct_csr.wr_ack <= 1'b0;
    end else begin
      dct_rd_ack_q   <= dct_csr.req & ~dct_csr.req_is_wr & ~dct_ctrl_busy;
      // Write still acked so the software side does not stall
      dct_wr_ack_q   <= dct_csr.req & dct_csr.req_is_wr & ~dct_ctrl_busy;
      dct_csr.rd_ack <= dct_rd_ack_q;
      dct_csr.wr_ack <= dct_wr_ack_q;
    end
  end

endmodule

// ==== csr_agent.sv ====
// ********************
// Software front end
// ********************

module csr_agent (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Request channel
  input  logic                    req_valid_i,
  input  i3c_dxt_pkg::csr_op_e    req_op_i,
  input  i3c_dxt_pkg::table_sel_e req_tbl_i,
  input  i3c_dxt_pkg::csr_addr_t  req_addr_i,
  input  i3c_dxt_pkg::csr_word_t  req_wdata_i,
  output logic                    req_ready_o,

  // Response channel
  output logic                    rsp_valid_o,
  output i3c_dxt_pkg::csr_word_t  rsp_data_o,
  input  logic                    rsp_ready_i,

  // Table access
  csr_hwif_if.host                dat_csr,
  csr_hwif_if.host                dct_csr
);
  import i3c_dxt_pkg::*;

  agent_state_e state_q;
  logic         wait_cnt_q;
  csr_op_e      op_q;
  table_sel_e   tbl_q;
  csr_addr_t    addr_q;
  csr_word_t    wdata_q;
  csr_word_t    rsp_data_q;
  logic         ack;
  logic         done;
  csr_word_t    rd_data;

  assign ack = (tbl_q == TBL_DCT) ? (dct_csr.rd_ack | dct_csr.wr_ack)
                                  : (dat_csr.rd_ack | dat_csr.wr_ack);
  assign rd_data = (tbl_q == TBL_DCT) ? dct_csr.rd_data : dat_csr.rd_data;

  // Second wait cycle is where the acknowledge must show up
  assign done = (state_q == AG_WAIT) && wait_cnt_q;

  // Request pulse only in the issue cycle
  assign dat_csr.req       = (state_q == AG_ISSUE) && (tbl_q == TBL_DAT);
  assign dat_csr.req_is_wr = (op_q == CSR_WRITE);
  assign dat_csr.addr      = addr_q;
  assign dat_csr.wr_data   = wdata_q;

  assign dct_csr.req       = (state_q == AG_ISSUE) && (tbl_q == TBL_DCT);
  assign dct_csr.req_is_wr = (op_q == CSR_WRITE);
  assign dct_csr.addr      = addr_q;
  assign dct_csr.wr_data   = wdata_q;

  assign req_ready_o = (state_q == AG_IDLE);
  assign rsp_valid_o = (state_q == AG_RESP);
  assign rsp_data_o  = rsp_data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= AG_IDLE;
      wait_cnt_q <= 1'b0;
      op_q       <= CSR_READ;
      tbl_q      <= TBL_DAT;
    end else begin
      case (state_q)
        AG_IDLE: begin
          if (req_valid_i) begin
            op_q    <= req_op_i;
            tbl_q   <= req_tbl_i;
            state_q <= AG_ISSUE;
          end
        end
        AG_ISSUE: begin
          wait_cnt_q <= 1'b0;
          state_q    <= AG_WAIT;
        end
        AG_WAIT: begin
          wait_cnt_q <= 1'b1;
          // No ack means the controller had the table, so retry
          if (wait_cnt_q) begin
            state_q <= ack ? AG_RESP : AG_ISSUE;
          end
        end
        AG_RESP: begin
          if (rsp_ready_i) begin
            state_q <= AG_IDLE;
          end
        end
        default: state_q <= AG_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_ready_o && req_valid_i) begin
      addr_q  <= req_addr_i;
      wdata_q <= req_wdata_i;
    end
    if (done && ack) begin
      rsp_data_q <= (op_q == CSR_WRITE) ? '0 : rd_data;
    end
  end

endmodule

// ==== i3c_dxt_top.sv ====
// ********************
// I3C device tables
// ********************

`include "i3c_dxt_settings.svh"

module i3c_dxt_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,

  // Software request and response
  input  logic                    sw_req_valid_i,
  input  i3c_dxt_pkg::csr_op_e    sw_req_op_i,
  input  i3c_dxt_pkg::table_sel_e sw_req_tbl_i,
  input  i3c_dxt_pkg::csr_addr_t  sw_req_addr_i,
  input  i3c_dxt_pkg::csr_word_t  sw_req_wdata_i,
  output logic                    sw_req_ready_o,
  output logic                    sw_rsp_valid_o,
  output i3c_dxt_pkg::csr_word_t  sw_rsp_data_o,
  input  logic                    sw_rsp_ready_i,

  // Controller DAT read
  input  logic                    dat_rd_valid_i,
  input  i3c_dxt_pkg::dat_index_t dat_rd_index_i,
  output i3c_dxt_pkg::dat_entry_t dat_rd_data_o,

  // Controller DCT access
  input  logic                    dct_rd_valid_i,
  input  logic                    dct_wr_valid_i,
  input  i3c_dxt_pkg::dct_index_t dct_index_i,
  input  i3c_dxt_pkg::dct_entry_t dct_wdata_i,
  output i3c_dxt_pkg::dct_entry_t dct_rd_data_o
);

  csr_hwif_if dat_csr_if ();
  csr_hwif_if dct_csr_if ();

  table_mem_if #(.WIDTH(`DAT_WIDTH), .DEPTH(`DAT_DEPTH)) dat_mem_if ();
  table_mem_if #(.WIDTH(`DCT_WIDTH), .DEPTH(`DCT_DEPTH)) dct_mem_if ();

  csr_agent u_csr_agent (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_valid_i (sw_req_valid_i),
    .req_op_i    (sw_req_op_i),
    .req_tbl_i   (sw_req_tbl_i),
    .req_addr_i  (sw_req_addr_i),
    .req_wdata_i (sw_req_wdata_i),
    .req_ready_o (sw_req_ready_o),
    .rsp_valid_o (sw_rsp_valid_o),
    .rsp_data_o  (sw_rsp_data_o),
    .rsp_ready_i (sw_rsp_ready_i),
    .dat_csr     (dat_csr_if),
    .dct_csr     (dct_csr_if)
  );

  dxt u_dxt (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .dat_rd_valid_i (dat_rd_valid_i),
    .dat_rd_index_i (dat_rd_index_i),
    .dat_rd_data_o  (dat_rd_data_o),
    .dct_rd_valid_i (dct_rd_valid_i),
    .dct_wr_valid_i (dct_wr_valid_i),
    .dct_index_i    (dct_index_i),
    .dct_wdata_i    (dct_wdata_i),
    .dct_rd_data_o  (dct_rd_data_o),
    .dat_csr        (dat_csr_if),
    .dct_csr        (dct_csr_if),
    .dat_mem        (dat_mem_if),
    .dct_mem        (dct_mem_if)
  );

  table_ram #(.WIDTH(`DAT_WIDTH), .DEPTH(`DAT_DEPTH)) u_dat_ram (
    .clk_i (clk_i),
    .mem   (dat_mem_if)
  );

  table_ram #(.WIDTH(`DCT_WIDTH), .DEPTH(`DCT_DEPTH)) u_dct_ram (
    .clk_i (clk_i),
    .mem   (dct_mem_if)
  );

endmodule

// ==== i3c_dxt_sva.sv ====
// ********************
// Handshake assertions
// ********************

module i3c_dxt_sva (
  input logic                   clk_i,
  input logic                   rst_ni,
  input logic                   dat_req,
  input logic                   dat_rd_ack,
  input logic                   dat_wr_ack,
  input logic                   dct_req,
  input logic                   dct_rd_ack,
  input logic                   dct_wr_ack,
  input logic                   sw_req_valid_i,
  input logic                   sw_req_ready_o,
  input i3c_dxt_pkg::csr_addr_t sw_req_addr_i,
  input logic                   sw_rsp_valid_o,
  input logic                   sw_rsp_ready_i,
  input i3c_dxt_pkg::csr_word_t sw_rsp_data_o
);

  // Acknowledge two cycles after the request
  dat_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dat_rd_ack || dat_wr_ack) |-> $past(dat_req, 2))
    else $error("DAT acknowledge without a request two cycles earlier");
  dct_ack_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (dct_rd_ack || dct_wr_ack) |-> $past(dct_req, 2))
    else $error("DCT acknowledge without a request two cycles earlier");

  ack_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(dat_rd_ack && dat_wr_ack) && !(dct_rd_ack && dct_wr_ack))
    else $error("Read and write acknowledge high together");

  // Channels hold while stalled
  req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sw_req_valid_i && !sw_req_ready_o) |=> (sw_req_valid_i && $stable(sw_req_addr_i)))
    else $error("Request changed while stalled");
  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (sw_rsp_valid_o && !sw_rsp_ready_i) |=> (sw_rsp_valid_o && $stable(sw_rsp_data_o)))
    else $error("Response changed while stalled");

endmodule

bind i3c_dxt_top i3c_dxt_sva u_sva (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .dat_req        (dat_csr_if.req),
  .dat_rd_ack     (dat_csr_if.rd_ack),
  .dat_wr_ack     (dat_csr_if.wr_ack),
  .dct_req        (dct_csr_if.req),
  .dct_rd_ack     (dct_csr_if.rd_ack),
  .dct_wr_ack     (dct_csr_if.wr_ack),
  .sw_req_valid_i (sw_req_valid_i),
  .sw_req_ready_o (sw_req_ready_o),
  .sw_req_addr_i  (sw_req_addr_i),
  .sw_rsp_valid_o (sw_rsp_valid_o),
  .sw_rsp_ready_i (sw_rsp_ready_i),
  .sw_rsp_data_o  (sw_rsp_data_o)
);

// ==== tb_i3c_dxt.sv ====
// ********************
// Device table testbench
// ********************

`include "i3c_dxt_settings.svh"

module tb_i3c_dxt;
  import i3c_dxt_pkg::*;

  logic       clk_i;
  logic       rst_ni;
  logic       sw_req_valid_i;
  csr_op_e    sw_req_op_i;
  table_sel_e sw_req_tbl_i;
  csr_addr_t  sw_req_addr_i;
  csr_word_t  sw_req_wdata_i;
  logic       sw_req_ready_o;
  logic       sw_rsp_valid_o;
  csr_word_t  sw_rsp_data_o;
  logic       sw_rsp_ready_i;
  logic       dat_rd_valid_i;
  dat_index_t dat_rd_index_i;
  dat_entry_t dat_rd_data_o;
  logic       dct_rd_valid_i;
  logic       dct_wr_valid_i;
  dct_index_t dct_index_i;
  dct_entry_t dct_wdata_i;
  dct_entry_t dct_rd_data_o;

  dat_entry_t  shadow_dat [`DAT_DEPTH];
  dct_entry_t  shadow_dct [`DCT_DEPTH];
  csr_word_t   exp_rsp_q [$];
  dat_entry_t  exp_dat_q [$];
  dct_entry_t  exp_dct_q [$];
  logic [15:0] lfsr_q = 16'd13442;
  logic [15:0] stall_q = 16'd13442;
  logic        stall_en;
  logic        dat_pend;
  logic        dct_pend;
  logic        rsp_hold;
  dat_entry_t  dat_exp;
  dct_entry_t  dct_exp;
  csr_word_t   rsp_last;

  i3c_dxt_top dut_i (.*);

  initial clk_i = 1'b0;
  always #10 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Expected response word, zero for writes
  function automatic csr_word_t ref_word(table_sel_e tbl, csr_addr_t addr, csr_op_e op);
    if (op == CSR_WRITE) return '0;
    if (tbl == TBL_DAT) return shadow_dat[addr[9:3]][int'(addr[2]) * 32 +: 32];
    return shadow_dct[addr[10:4]][int'(addr[3:2]) * 32 +: 32];
  endfunction

  function automatic csr_addr_t make_addr(table_sel_e tbl, int idx, int sel);
    csr_addr_t a;
    a = '0;
    if (tbl == TBL_DAT) begin
      a[9:3] = idx[6:0];
      a[2]   = sel[0];
    end else begin
      a[10:4] = idx[6:0];
      a[3:2]  = sel[1:0];
    end
    return a;
  endfunction

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input csr_word_t exp, input csr_word_t act);
    if (act !== exp) fail_stop($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_dat(input string name, input dat_entry_t exp, input dat_entry_t act);
    if (act !== exp) fail_stop($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_dct(input string name, input dct_entry_t exp, input dct_entry_t act);
    if (act !== exp) fail_stop($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  // One software request, expected value taken at acceptance
  task automatic sw_access(input csr_op_e op, input table_sel_e tbl, input csr_addr_t addr,
                           input csr_word_t wdata);
    int t;
    t = 0;
    @(negedge clk_i);
    sw_req_valid_i <= 1'b1;
    sw_req_op_i    <= op;
    sw_req_tbl_i   <= tbl;
    sw_req_addr_i  <= addr;
    sw_req_wdata_i <= wdata;
    // Held while the agent is busy
    while (!sw_req_ready_o) begin
      t++;
      if (t > 300) fail_stop("Timeout waiting for sw_req_ready_o");
      @(negedge clk_i);
    end
    // Taken at the next rising edge
    exp_rsp_q.push_back(ref_word(tbl, addr, op));
    if (op == CSR_WRITE && tbl == TBL_DAT) begin
      shadow_dat[addr[9:3]][int'(addr[2]) * 32 +: 32] = wdata;
    end
    @(negedge clk_i);
    sw_req_valid_i <= 1'b0;
  endtask

  task automatic sw_random();
    table_sel_e tbl;
    csr_op_e    op;
    tbl = rand_bits(1) ? TBL_DCT : TBL_DAT;
    op  = rand_bits(1) ? CSR_WRITE : CSR_READ;
    sw_access(op, tbl, make_addr(tbl, int'(rand_bits(3)), int'(rand_bits(2))), rand_bits(32));
  endtask

  // Kind 0 DAT read, 1 DCT read, 2 DCT write
  task automatic ctrl_op(input int kind, input int idx);
    dct_entry_t d;
    @(negedge clk_i);
    if (kind == 0) begin
      dat_rd_valid_i <= 1'b1;
      dat_rd_index_i <= dat_index_t'(idx);
      exp_dat_q.push_back(shadow_dat[idx]);
    end else if (kind == 1) begin
      dct_rd_valid_i <= 1'b1;
      dct_index_i    <= dct_index_t'(idx);
      exp_dct_q.push_back(shadow_dct[idx]);
    end else begin
      d = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
      dct_wr_valid_i <= 1'b1;
      dct_index_i    <= dct_index_t'(idx);
      dct_wdata_i    <= d;
      shadow_dct[idx] = d;
    end
    @(negedge clk_i);
    dat_rd_valid_i <= 1'b0;
    dct_rd_valid_i <= 1'b0;
    dct_wr_valid_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_rsp_q.size() != 0 || exp_dat_q.size() != 0 || exp_dct_q.size() != 0
           || dat_pend || dct_pend) begin
      t++;
      if (t > 500) fail_stop("Timeout waiting for outstanding responses");
      @(negedge clk_i);
    end
  endtask

  always @(negedge clk_i) begin
    sw_rsp_ready_i <= 1'b1;
    if (stall_en) begin
      stall_q = lfsr_next(stall_q);
      sw_rsp_ready_i <= stall_q[0];
    end
  end

  // Compares just after the drive edge, outputs settled
  always @(negedge clk_i) begin
    #1;
    if (dat_pend) check_dat("ctrl DAT read", dat_exp, dat_rd_data_o);
    if (dct_pend) check_dct("ctrl DCT read", dct_exp, dct_rd_data_o);
    dat_pend = dat_rd_valid_i;
    dct_pend = dct_rd_valid_i;
    if (dat_rd_valid_i) dat_exp = exp_dat_q.pop_front();
    if (dct_rd_valid_i) dct_exp = exp_dct_q.pop_front();
    if (rsp_hold && (!sw_rsp_valid_o || sw_rsp_data_o !== rsp_last))
      fail_stop("Response changed while sw_rsp_ready_i was low");
    if (sw_rsp_valid_o && sw_req_ready_o) fail_stop("Request ready while a response is pending");
    if (sw_rsp_valid_o && sw_rsp_ready_i) begin
      if (exp_rsp_q.size() == 0) fail_stop("Response without a request");
      check_word("sw response", exp_rsp_q.pop_front(), sw_rsp_data_o);
    end
    rsp_hold = sw_rsp_valid_o && !sw_rsp_ready_i;
    rsp_last = sw_rsp_data_o;
  end

  initial begin
    #1000000;
    fail_stop("Global timeout, simulation did not finish");
  end

  initial begin
    int idx;
    rst_ni = 1'b0;
    sw_req_valid_i = 1'b0;
    sw_req_op_i = CSR_READ;
    sw_req_tbl_i = TBL_DAT;
    sw_req_addr_i = '0;
    sw_req_wdata_i = '0;
    sw_rsp_ready_i = 1'b1;
    dat_rd_valid_i = 1'b0;
    dat_rd_index_i = '0;
    dct_rd_valid_i = 1'b0;
    dct_wr_valid_i = 1'b0;
    dct_index_i = '0;
    dct_wdata_i = '0;
    stall_en = 1'b0;
    dat_pend = 1'b0;
    dct_pend = 1'b0;
    rsp_hold = 1'b0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;

    // Software DAT writes, partial overwrite, read back
    for (int i = 0; i < 16; i++) begin
      idx = (i < 8) ? i : 56 + i;
      for (int s = 0; s < 2; s++) begin
        sw_access(CSR_WRITE, TBL_DAT, make_addr(TBL_DAT, idx, s), rand_bits(32));
      end
    end
    for (int i = 0; i < 4; i++) begin
      sw_access(CSR_WRITE, TBL_DAT, make_addr(TBL_DAT, i, 0), rand_bits(32));
    end
    for (int i = 0; i < 16; i++) begin
      idx = (i < 8) ? i : 56 + i;
      for (int s = 0; s < 2; s++) sw_access(CSR_READ, TBL_DAT, make_addr(TBL_DAT, idx, s), '0);
    end
    wait_drain();

    // Controller DAT reads of whole entries
    for (int i = 0; i < 16; i++) ctrl_op(0, (i < 8) ? i : 56 + i);
    wait_drain();

    // Controller DCT writes, software word reads, controller reads
    for (int i = 0; i < 16; i++) ctrl_op(2, (i < 8) ? i : 56 + i);
    for (int i = 0; i < 8; i++) begin
      idx = (i < 4) ? i : 60 + i;
      for (int s = 0; s < 4; s++) sw_access(CSR_READ, TBL_DCT, make_addr(TBL_DCT, idx, s), '0);
    end
    for (int i = 0; i < 16; i++) ctrl_op(1, (i < 8) ? i : 56 + i);
    wait_drain();

    // Software DCT writes are ignored
    for (int i = 0; i < 4; i++) begin
      sw_access(CSR_WRITE, TBL_DCT, make_addr(TBL_DCT, i, i), rand_bits(32));
    end
    for (int i = 0; i < 4; i++) sw_access(CSR_READ, TBL_DCT, make_addr(TBL_DCT, i, i), '0);
    wait_drain();

    // Concurrent traffic on separate entry ranges, with response stalls
    stall_en = 1'b1;
    fork
      for (int i = 0; i < 40; i++) sw_random();
      for (int i = 0; i < 60; i++) ctrl_op(int'(rand_bits(2)) % 3, 64 + int'(rand_bits(3)));
    join
    wait_drain();
    for (int i = 0; i < 20; i++) sw_random();
    wait_drain();

    $display("sim passed");
    $finish;
  end

endmodule

// ==== i3c_dxt_top.f ====
+incdir+.
i3c_dxt_pkg.sv
dxt_if.sv
table_ram.sv
dxt.sv
csr_agent.sv
i3c_dxt_top.sv
i3c_dxt_sva.sv
tb_i3c_dxt.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_i3c_dxt -f i3c_dxt_top.f -o sim_i3c_dxt

./obj_dir/sim_i3c_dxt > sim.log 2>&1 || true
cat sim.log

if grep -q "sim failed" sim.log; then
  exit 1
fi
grep -q "sim passed" sim.log
